/* lsu_cfg.svh */
// Sizing macros for the load/store unit, its data TLB and the data RAM
// Include before any package or module that derives a width from them
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data and address width
`define LSU_DW 32

// Page offset bits, 256-byte pages
`define LSU_P_PAGE 8

// TLB index bits, 16 direct-mapped entries
`define DTLB_P_SETS 4

// RAM word index bits, 4 KiB of data
`define DRAM_P_WORDS 10

`endif

/* logic/lsu_pkg.sv */
// Load/store types shared by the LSU control and datapath
// Opcode bus layout, access size and the data, address and mask vectors
`include "lsu_cfg.svh"

package lsu_pkg;

   typedef logic [`LSU_DW-1:0]   data_t;
   typedef logic [`LSU_DW-1:0]   addr_t;   // Virtual or physical
   typedef logic [`LSU_DW/8-1:0] wmsk_t;   // One bit per byte lane

   typedef enum logic [1:0] {
      SIZE_B = 2'd0,
      SIZE_H = 2'd1,
      SIZE_W = 2'd2
   } lsu_size_e;

   // Opcode bus from the issue stage
   typedef logic [4:0] lsu_opc_t;

   localparam int OPC_LOAD     = 0;
   localparam int OPC_STORE    = 1;
   localparam int OPC_SIGN     = 2;   // Sign extend the load result
   localparam int OPC_SIZE_LSB = 3;   // Two size bits from here

endpackage

/* logic/dmmu_pkg.sv */
// Translation types for the data TLB
// Page numbers, TLB index and the field positions of the TLBL/TLBH words
`include "lsu_cfg.svh"

package dmmu_pkg;

   typedef logic [`LSU_DW-`LSU_P_PAGE-1:0] vpn_t;
   typedef logic [`LSU_DW-`LSU_P_PAGE-1:0] ppn_t;
   typedef logic [`DTLB_P_SETS-1:0]        tlb_idx_t;

   // TLBL word
   localparam int TLBL_V = 0;   // Entry valid

   // TLBH word
   localparam int TLBH_R = 0;   // Page readable
   localparam int TLBH_W = 1;   // Page writable

   // VPN tag and PPN both start above the page offset
   localparam int TLB_PN_LSB = `LSU_P_PAGE;

endpackage

/* logic/lsu_ctrl.sv */
// Control of the LSU that decodes the opcode, tracks stage valids and issues RAM accesses
// Sits between the issue stage and the LSU datapath inside ex_lsu
`timescale 1ns/1ps

module lsu_ctrl (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               p_ce_s1,
   input  logic               flush_s1,
   input  logic               ex_valid,
   input  lsu_pkg::lsu_opc_t  opc,
   input  logic               misalign,
   input  logic               tlb_edtm,
   input  logic               tlb_edpf,
   output logic               s0_load,
   output logic               s0_store,
   output logic               s0_sign,
   output lsu_pkg::lsu_size_e s0_size,
   output logic               tlb_req,
   output logic               ram_en,
   output logic               ram_we,
   output logic               lsu_edtm,
   output logic               lsu_edpf,
   output logic               lsu_ealign,
   output logic               lsu_load_valid
);
   import lsu_pkg::*;

   logic s0_valid;
   logic s1_valid;
   logic s1_load;
   logic s1_store;
   logic s1_misalign;
   logic s1_exc;

   assign s0_load  = opc[OPC_LOAD];
   assign s0_store = opc[OPC_STORE];
   assign s0_sign  = opc[OPC_SIGN];
   assign s0_size  = lsu_size_e'(opc[OPC_SIZE_LSB +: 2]);
   assign s0_valid = ex_valid & ~flush_s1 & (s0_load | s0_store);

   // Fire only on ce so a stalled op is not looked up twice
   assign tlb_req = p_ce_s1 & s0_valid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else if (p_ce_s1 | flush_s1) begin
         s1_valid <= s0_valid;   // s0_valid is low during a flush
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_load        <= 1'b0;
         s1_store       <= 1'b0;
         s1_misalign    <= 1'b0;
         lsu_load_valid <= 1'b0;
      end else if (p_ce_s1) begin
         s1_load        <= s0_load;
         s1_store       <= s0_store;
         s1_misalign    <= misalign;
         lsu_load_valid <= s1_valid & s1_load & ~s1_exc;
      end
   end

   assign s1_exc = s1_misalign | tlb_edtm | tlb_edpf;

   assign lsu_edtm   = s1_valid & tlb_edtm;
   assign lsu_edpf   = s1_valid & tlb_edpf;
   assign lsu_ealign = s1_valid & s1_misalign;

   // Faulting ops never reach the RAM
   assign ram_en = p_ce_s1 & s1_valid & ~s1_exc;
   assign ram_we = ram_en & s1_store;

   // A flushed stage can neither fault nor reach the RAM
   a_flush_kills_s1: assert property (@(posedge clk) disable iff (!rst_n)
      flush_s1 |=> !(lsu_edtm | lsu_edpf | lsu_ealign | ram_en));

endmodule

/* logic/lsu_store_align.sv */
// Store alignment: lane replication, byte write mask and misalignment check
// Data and mask are captured on ce for the RAM write in the access stage
`timescale 1ns/1ps

module lsu_store_align (
   input  logic               clk,
   input  logic               p_ce_s1,
   input  lsu_pkg::lsu_size_e size,
   input  logic               store,
   input  lsu_pkg::addr_t     vaddr,
   input  lsu_pkg::data_t     wdata_in,
   output logic               misalign,
   output lsu_pkg::data_t     s1_wdat,
   output lsu_pkg::wmsk_t     s1_wmsk
);
   import lsu_pkg::*;

   data_t wdat;
   wmsk_t wmsk;

   always_comb begin
      case (size)
         SIZE_B:  wdat = {4{wdata_in[7:0]}};
         SIZE_H:  wdat = {2{wdata_in[15:0]}};
         default: wdat = wdata_in;
      endcase
   end

   // Byte lanes picked by the low address bits
   always_comb begin
      case (size)
         SIZE_B:  wmsk = wmsk_t'(4'b0001 << vaddr[1:0]);
         SIZE_H:  wmsk = vaddr[1] ? 4'b1100 : 4'b0011;
         default: wmsk = 4'b1111;
      endcase
      if (!store) wmsk = '0;   // Loads write nothing
   end

   assign misalign = (size == SIZE_H & vaddr[0]) | (size == SIZE_W & |vaddr[1:0]);

   always_ff @(posedge clk) begin
      if (p_ce_s1) begin
         s1_wdat <= wdat;
         s1_wmsk <= wmsk;
      end
   end

endmodule

/* logic/dtlb.sv */
// Direct-mapped data TLB that software writes through the TLBL/TLBH ports
// Lookup is captured at the request; translation and checks are valid in s1
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module dtlb (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req,
   input  dmmu_pkg::vpn_t     vpn,
   input  logic               store,
   input  logic               dmme,
   input  dmmu_pkg::tlb_idx_t tlbl_idx,
   input  lsu_pkg::data_t     tlbl_nxt,
   input  logic               tlbl_we,
   input  dmmu_pkg::tlb_idx_t tlbh_idx,
   input  lsu_pkg::data_t     tlbh_nxt,
   input  logic               tlbh_we,
   output dmmu_pkg::ppn_t     ppn,
   output logic               edtm,
   output logic               edpf
);
   import dmmu_pkg::*;

   logic [(1<<`DTLB_P_SETS)-1:0] ent_v;
   logic [(1<<`DTLB_P_SETS)-1:0] ent_r;
   logic [(1<<`DTLB_P_SETS)-1:0] ent_w;
   vpn_t     ent_tag [0:(1<<`DTLB_P_SETS)-1];
   ppn_t     ent_ppn [0:(1<<`DTLB_P_SETS)-1];
   tlb_idx_t idx;
   logic     lk_v;
   logic     lk_dmme;
   logic     lk_r;
   logic     lk_w;
   logic     lk_store;
   vpn_t     lk_tag;
   vpn_t     lk_vpn;
   ppn_t     lk_ppn;
   logic     hit;

   assign idx = vpn[`DTLB_P_SETS-1:0];   // Low VPN bits pick the set

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ent_v   <= '0;
         lk_v    <= 1'b0;
         lk_dmme <= 1'b0;
      end else begin
         if (tlbl_we) ent_v[tlbl_idx] <= tlbl_nxt[TLBL_V];
         if (req) begin
            lk_v    <= ent_v[idx];
            lk_dmme <= dmme;
         end
      end
   end

   // Entry fields and lookup payload
   always_ff @(posedge clk) begin
      if (tlbl_we) ent_tag[tlbl_idx] <= tlbl_nxt[`LSU_DW-1:TLB_PN_LSB];
      if (tlbh_we) begin
         ent_ppn[tlbh_idx] <= tlbh_nxt[`LSU_DW-1:TLB_PN_LSB];
         ent_r[tlbh_idx]   <= tlbh_nxt[TLBH_R];
         ent_w[tlbh_idx]   <= tlbh_nxt[TLBH_W];
      end
      if (req) begin
         lk_tag   <= ent_tag[idx];
         lk_ppn   <= ent_ppn[idx];
         lk_r     <= ent_r[idx];
         lk_w     <= ent_w[idx];
         lk_vpn   <= vpn;
         lk_store <= store;
      end
   end

   assign hit  = lk_v & (lk_tag == lk_vpn);
   assign edtm = lk_dmme & ~hit;
   assign edpf = lk_dmme & hit & (lk_store ? ~lk_w : ~lk_r);
   assign ppn  = lk_dmme ? lk_ppn : lk_vpn;   // Identity map when off

   // With translation off the page maps to itself and never faults
   a_off_is_identity: assert property (@(posedge clk) disable iff (!rst_n)
      (req & !dmme) |=> (!(edtm | edpf) && ppn == $past(vpn)));

endmodule

/* logic/dram.sv */
// Tightly coupled data RAM, byte-writable, one access per enabled edge
// Read data is registered and holds until the next enabled access
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module dram (
   input  logic           clk,
   input  logic           en,
   input  logic           we,
   input  lsu_pkg::wmsk_t wmsk,
   input  lsu_pkg::addr_t addr,
   input  lsu_pkg::data_t wdat,
   output lsu_pkg::data_t rdat
);
   import lsu_pkg::*;

   data_t                   mem [0:(1<<`DRAM_P_WORDS)-1];
   logic [`DRAM_P_WORDS-1:0] widx;

   assign widx = addr[`DRAM_P_WORDS+1:2];

   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            for (int i = 0; i < `LSU_DW/8; i++) begin
               if (wmsk[i]) begin
                  mem[widx][8*i +: 8] <= wdat[8*i +: 8];
               end
            end
         end
         rdat <= mem[widx];   // Old word on read during write
      end
   end

endmodule

/* logic/lsu_load_align.sv */
// Load alignment: carries size, sign and offset to the result stage
// then picks the byte or halfword from the RAM word and extends it
`timescale 1ns/1ps

module lsu_load_align (
   input  logic               clk,
   input  logic               p_ce_s1,
   input  lsu_pkg::lsu_size_e size,
   input  logic               sign,
   input  logic [1:0]         offset,
   input  lsu_pkg::data_t     rdat,
   output lsu_pkg::data_t     dout
);
   import lsu_pkg::*;

   lsu_size_e  s1_size;
   lsu_size_e  s2_size;
   logic       s1_sign;
   logic       s2_sign;
   logic [1:0] s1_off;
   logic [1:0] s2_off;
   logic [7:0]  rd_b;
   logic [15:0] rd_h;

   always_ff @(posedge clk) begin
      if (p_ce_s1) begin
         s1_size <= size;
         s1_sign <= sign;
         s1_off  <= offset;
         s2_size <= s1_size;
         s2_sign <= s1_sign;
         s2_off  <= s1_off;
      end
   end

   assign rd_b = rdat[8*s2_off +: 8];
   assign rd_h = s2_off[1] ? rdat[31:16] : rdat[15:0];

   always_comb begin
      case (s2_size)
         SIZE_B:  dout = {{24{s2_sign & rd_b[7]}}, rd_b};
         SIZE_H:  dout = {{16{s2_sign & rd_h[15]}}, rd_h};
         default: dout = rdat;
      endcase
   end

endmodule

/* logic/ex_lsu.sv */
// Load/store unit of the execute stage: control, TLB, RAM and alignment
// Exceptions one ce edge after issue, load data after the second
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module ex_lsu (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               p_ce_s1,
   input  logic               flush_s1,
   input  logic               ex_valid,
   input  lsu_pkg::lsu_opc_t  ex_lsu_opc_bus,
   input  lsu_pkg::addr_t     add_sum,       // Effective address
   input  lsu_pkg::data_t     ex_operand2,   // Store data
   input  logic               msr_psr_dmme,
   input  dmmu_pkg::tlb_idx_t msr_dmm_tlbl_idx,
   input  lsu_pkg::data_t     msr_dmm_tlbl_nxt,
   input  logic               msr_dmm_tlbl_we,
   input  dmmu_pkg::tlb_idx_t msr_dmm_tlbh_idx,
   input  lsu_pkg::data_t     msr_dmm_tlbh_nxt,
   input  logic               msr_dmm_tlbh_we,
   output logic               lsu_edtm,
   output logic               lsu_edpf,
   output logic               lsu_ealign,
   output lsu_pkg::addr_t     lsu_vaddr,
   output lsu_pkg::data_t     lsu_dout,
   output logic               lsu_load_valid
);
   import lsu_pkg::*;
   import dmmu_pkg::*;

   logic      s0_load;
   logic      s0_store;
   logic      s0_sign;
   lsu_size_e s0_size;
   logic      misalign;
   logic      tlb_req;
   logic      tlb_edtm;
   logic      tlb_edpf;
   ppn_t      tlb_ppn;
   logic      ram_en;
   logic      ram_we;
   addr_t     s1_vaddr;
   addr_t     ram_paddr;
   data_t     s1_wdat;
   wmsk_t     s1_wmsk;
   data_t     ram_rdat;

   always_ff @(posedge clk) begin
      if (p_ce_s1) s1_vaddr <= add_sum;
   end

   assign lsu_vaddr = s1_vaddr;
   assign ram_paddr = {tlb_ppn, s1_vaddr[`LSU_P_PAGE-1:0]};   // PPN plus page offset

   lsu_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n), .p_ce_s1(p_ce_s1), .flush_s1(flush_s1),
      .ex_valid(ex_valid), .opc(ex_lsu_opc_bus), .misalign(misalign),
      .tlb_edtm(tlb_edtm), .tlb_edpf(tlb_edpf),
      .s0_load(s0_load), .s0_store(s0_store), .s0_sign(s0_sign), .s0_size(s0_size),
      .tlb_req(tlb_req), .ram_en(ram_en), .ram_we(ram_we),
      .lsu_edtm(lsu_edtm), .lsu_edpf(lsu_edpf), .lsu_ealign(lsu_ealign),
      .lsu_load_valid(lsu_load_valid)
   );

   lsu_store_align u_store_align (
      .clk(clk), .p_ce_s1(p_ce_s1), .size(s0_size), .store(s0_store),
      .vaddr(add_sum), .wdata_in(ex_operand2),
      .misalign(misalign), .s1_wdat(s1_wdat), .s1_wmsk(s1_wmsk)
   );

   dtlb u_dtlb (
      .clk(clk), .rst_n(rst_n), .req(tlb_req),
      .vpn(add_sum[`LSU_DW-1:`LSU_P_PAGE]), .store(s0_store), .dmme(msr_psr_dmme),
      .tlbl_idx(msr_dmm_tlbl_idx), .tlbl_nxt(msr_dmm_tlbl_nxt), .tlbl_we(msr_dmm_tlbl_we),
      .tlbh_idx(msr_dmm_tlbh_idx), .tlbh_nxt(msr_dmm_tlbh_nxt), .tlbh_we(msr_dmm_tlbh_we),
      .ppn(tlb_ppn), .edtm(tlb_edtm), .edpf(tlb_edpf)
   );

   dram u_dram (
      .clk(clk), .en(ram_en), .we(ram_we), .wmsk(s1_wmsk),
      .addr(ram_paddr), .wdat(s1_wdat), .rdat(ram_rdat)
   );

   lsu_load_align u_load_align (
      .clk(clk), .p_ce_s1(p_ce_s1), .size(s0_size), .sign(s0_sign),
      .offset(add_sum[1:0]), .rdat(ram_rdat), .dout(lsu_dout)
   );

endmodule

/* testbench/tb_ex_lsu.sv */
// Testbench for ex_lsu with random loads and stores from a fixed seed
// A model of the TLB, the data RAM and the two pipeline stages predicts every output
`timescale 1ns/1ps

module tb_ex_lsu;
   import lsu_pkg::*;
   import dmmu_pkg::*;

   localparam int N_FILL  = 1024;
   localparam int N_OPS   = 400 + 180 + 200 + 200 + 400;   // All five phases
   localparam int N_SETUP = 3 + N_FILL + 3 * 16 * 2 + 32;
   localparam int LIMIT   = N_OPS * 4 + N_SETUP;

   logic clk = 1'b0;
   logic rst_n, p_ce_s1, flush_s1, ex_valid, msr_psr_dmme;
   lsu_opc_t ex_lsu_opc_bus;
   addr_t    add_sum;
   data_t    ex_operand2, msr_dmm_tlbl_nxt, msr_dmm_tlbh_nxt;
   tlb_idx_t msr_dmm_tlbl_idx, msr_dmm_tlbh_idx;
   logic     msr_dmm_tlbl_we, msr_dmm_tlbh_we;
   logic     lsu_edtm, lsu_edpf, lsu_ealign, lsu_load_valid;
   addr_t    lsu_vaddr;
   data_t    lsu_dout;

   logic [7:0] mem_b [0:4095];   // Byte image of the RAM
   data_t      tlbl_mem [0:15];
   data_t      tlbh_mem [0:15];
   logic       m_valid, m_load, m_store, m_sign, m_edtm, m_edpf, m_ealign;
   lsu_size_e  m_size;
   addr_t      m_vaddr, m_paddr;
   data_t      m_wdat, m_dout;
   logic       m_lv;
   logic [31:0] rng = 32'h544d5560;
   int          cycles = 0;

   ex_lsu dut0 (.*);

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic logic [1:0] pick_size(input logic [1:0] r);
      return (r == 2'd3) ? 2'd2 : r;   // No size 3
   endfunction

   // Natural alignment inside the 4 KiB RAM
   function automatic addr_t align_addr(input addr_t a, input logic [1:0] sz);
      return a & 32'hfff & ~((32'd1 << sz) - 32'd1);
   endfunction

   function automatic data_t fill_word(input addr_t a);
      return (a * 32'h9e3779b1) ^ 32'h6a09e667;
   endfunction

   function automatic data_t load_word(input addr_t pa, input lsu_size_e sz, input logic sgn);
      logic [11:0] a;
      logic [15:0] h;
      a = pa[11:0];
      h = {mem_b[a + 12'd1], mem_b[a]};
      case (sz)
         SIZE_B:  return {{24{sgn & mem_b[a][7]}}, mem_b[a]};
         SIZE_H:  return {{16{sgn & h[15]}}, h};
         default: return {mem_b[a + 12'd3], mem_b[a + 12'd2], h};
      endcase
   endfunction

   task automatic store_bytes(input addr_t pa, input lsu_size_e sz, input data_t d);
      for (int i = 0; i < (1 << sz); i++) begin
         mem_b[pa[11:0] + 12'(i)] = d[8*i +: 8];
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED time=%0t %s got=%h expected=%h",
                             $time, name, got, exp));
      end
   endtask

   // One clock edge of the pipeline as seen before this edge's new inputs land
   task automatic model_edge();
      logic        exc;
      logic [23:0] vpn;
      data_t       lo;
      data_t       hi;
      exc = m_edtm | m_edpf | m_ealign;
      if (p_ce_s1) begin
         if (m_valid && !exc && m_store) store_bytes(m_paddr, m_size, m_wdat);
         m_lv = m_valid & m_load & ~exc;
         if (m_lv) m_dout = load_word(m_paddr, m_size, m_sign);
         m_valid = ex_valid & ~flush_s1 & (ex_lsu_opc_bus[OPC_LOAD] | ex_lsu_opc_bus[OPC_STORE]);
         if (m_valid) begin
            m_load   = ex_lsu_opc_bus[OPC_LOAD];
            m_store  = ex_lsu_opc_bus[OPC_STORE];
            m_sign   = ex_lsu_opc_bus[OPC_SIGN];
            m_size   = lsu_size_e'(ex_lsu_opc_bus[OPC_SIZE_LSB +: 2]);
            m_vaddr  = add_sum;
            m_wdat   = ex_operand2;
            m_ealign = (m_size == SIZE_H && add_sum[0]) || (m_size == SIZE_W && add_sum[1:0] != 0);
            vpn      = add_sum[31:8];
            lo       = tlbl_mem[vpn[3:0]];
            hi       = tlbh_mem[vpn[3:0]];
            m_edtm   = msr_psr_dmme & ~(lo[0] & (lo[31:8] == vpn));
            m_edpf   = msr_psr_dmme & ~m_edtm & (m_store ? ~hi[1] : ~hi[0]);
            m_paddr  = msr_psr_dmme ? {hi[31:8], add_sum[7:0]} : add_sum;
         end
      end else if (flush_s1) begin
         m_valid = 1'b0;   // Flush kills s1 even without ce
      end
      if (msr_dmm_tlbl_we) tlbl_mem[msr_dmm_tlbl_idx] = msr_dmm_tlbl_nxt;
      if (msr_dmm_tlbh_we) tlbh_mem[msr_dmm_tlbh_idx] = msr_dmm_tlbh_nxt;
   endtask

   task automatic check_outputs();
      check_value("lsu_edtm", 32'(lsu_edtm), 32'(m_valid & m_edtm));
      check_value("lsu_edpf", 32'(lsu_edpf), 32'(m_valid & m_edpf));
      check_value("lsu_ealign", 32'(lsu_ealign), 32'(m_valid & m_ealign));
      if (m_valid) check_value("lsu_vaddr", lsu_vaddr, m_vaddr);
      check_value("lsu_load_valid", 32'(lsu_load_valid), 32'(m_lv));
      if (m_lv) check_value("lsu_dout", lsu_dout, m_dout);
   endtask

   always @(posedge clk) if (rst_n) model_edge();
   always @(negedge clk) if (rst_n) check_outputs();   // Outputs settled mid-cycle

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= LIMIT) abort_run($sformatf("Timeout: run not done after %0d cycles", LIMIT));
   end

   task automatic drive(input logic vld, input logic st, input logic [1:0] sz, input logic sgn,
                        input addr_t a, input data_t d, input logic ce, input logic fl);
      @(posedge clk);
      ex_valid       <= vld;
      ex_lsu_opc_bus <= {sz, sgn, st, ~st};
      add_sum        <= a;
      ex_operand2    <= d;
      p_ce_s1        <= ce;
      flush_s1       <= fl;
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, 1'b0, 2'd2, 1'b0, '0, '0, 1'b1, 1'b0);
   endtask

   task automatic random_op(input logic vld, input logic ce, input logic fl);
      logic [31:0] r;
      logic [1:0]  sz;
      r  = next_rand();
      sz = pick_size(r[1:0]);
      drive(vld, r[2], sz, r[3], align_addr(next_rand(), sz), next_rand(), ce, fl);
   endtask

   task automatic write_tlb(input tlb_idx_t idx, input data_t lo, input data_t hi);
      @(posedge clk);
      ex_valid         <= 1'b0;
      msr_dmm_tlbl_idx <= idx;
      msr_dmm_tlbl_nxt <= lo;
      msr_dmm_tlbl_we  <= 1'b1;
      msr_dmm_tlbh_idx <= idx;
      msr_dmm_tlbh_nxt <= hi;
      msr_dmm_tlbh_we  <= 1'b1;
      @(posedge clk);
      msr_dmm_tlbl_we <= 1'b0;
      msr_dmm_tlbh_we <= 1'b0;
   endtask

   initial begin
      logic [31:0] r;
      addr_t       a;
      logic [1:0]  sz;
      rst_n = 1'b0;
      p_ce_s1 = 1'b1;
      flush_s1 = 1'b0;
      ex_valid = 1'b0;
      ex_lsu_opc_bus = '0;
      add_sum = '0;
      ex_operand2 = '0;
      msr_psr_dmme = 1'b0;
      msr_dmm_tlbl_idx = '0;
      msr_dmm_tlbl_nxt = '0;
      msr_dmm_tlbl_we = 1'b0;
      msr_dmm_tlbh_idx = '0;
      msr_dmm_tlbh_nxt = '0;
      msr_dmm_tlbh_we = 1'b0;
      m_valid = 1'b0;
      m_lv = 1'b0;
      for (int i = 0; i < 16; i++) begin
         tlbl_mem[i] = '0;   // Valid bits clear after reset
         tlbh_mem[i] = '0;
      end
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;

      // Fill the whole RAM and then identity map every TLB entry
      for (int i = 0; i < N_FILL; i++) begin
         drive(1'b1, 1'b1, 2'd2, 1'b0, 32'(i * 4), fill_word(32'(i * 4)), 1'b1, 1'b0);
      end
      for (int i = 0; i < 16; i++) write_tlb(4'(i), {24'(i), 8'h01}, {24'(i), 8'h03});

      // Store then load back with translation off
      for (int i = 0; i < 200; i++) begin
         r  = next_rand();
         sz = pick_size(r[1:0]);
         a  = align_addr(next_rand(), sz);
         drive(1'b1, 1'b1, sz, 1'b0, a, next_rand(), 1'b1, 1'b0);
         drive(1'b1, 1'b0, sz, r[2], a, '0, 1'b1, 1'b0);
      end

      // Misaligned store and load followed by an aligned word load
      for (int i = 0; i < 60; i++) begin
         r  = next_rand();
         sz = r[0] ? 2'd1 : 2'd2;
         a  = next_rand() & 32'hffc;
         a[1:0] = (sz == 2'd1) ? {r[1], 1'b1} : ((r[2:1] == 2'b00) ? 2'b10 : r[2:1]);
         drive(1'b1, 1'b1, sz, 1'b0, a, next_rand(), 1'b1, 1'b0);
         drive(1'b1, 1'b0, sz, r[3], a, '0, 1'b1, 1'b0);
         drive(1'b1, 1'b0, 2'd2, 1'b0, a & 32'hffc, '0, 1'b1, 1'b0);
      end
      idle(3);

      // Random page map with full permission
      for (int i = 0; i < 16; i++) begin
         r = next_rand();
         write_tlb(4'(i), {24'(i), 8'h01}, {20'd0, r[3:0], 8'h03});
      end
      msr_psr_dmme <= 1'b1;
      for (int i = 0; i < 200; i++) random_op(1'b1, 1'b1, 1'b0);
      idle(3);

      // Invalid entries, wrong tags and missing R or W
      for (int i = 0; i < 16; i++) begin
         r = next_rand();
         write_tlb(4'(i), {(r[2] & r[3]) ? 24'(i + 16) : 24'(i), 7'd0, r[0] | r[1]},
                   {20'd0, r[11:8], 6'd0, r[6] | r[7], r[4] | r[5]});
      end
      for (int i = 0; i < 200; i++) random_op(1'b1, 1'b1, 1'b0);

      // Random ce gaps and flush pulses
      for (int i = 0; i < 400; i++) begin
         r = next_rand();
         random_op(r[5] | r[6], r[0] | r[1], r[2] & r[3] & r[4]);
      end
      idle(4);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* src.f */
+incdir+.
logic/lsu_pkg.sv
logic/dmmu_pkg.sv
logic/lsu_ctrl.sv
logic/lsu_store_align.sv
logic/dtlb.sv
logic/dram.sv
logic/lsu_load_align.sv
logic/ex_lsu.sv
testbench/tb_ex_lsu.sv

/* Makefile */
# Verilator build and run of the ex_lsu testbench
# Override any variable on the command line, e.g. make test OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_ex_lsu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
